// ==== files.f ====
source/uart_reg_pkg.sv
source/uart_line_pkg.sv
source/sync_fifo.sv
source/uart_transmit.sv
source/uart_receive.sv
source/uart.sv
verif/uart_tb.sv

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
#(
	parameter WIDTH = 8,
	parameter DEPTH = 8
)
(
	input clk,
	input rst_n,
	input enqueue_en,
	input [WIDTH-1:0] value_in,
	input dequeue_en,
	output [WIDTH-1:0] value_out,
	output empty,
	output full
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	// Storage, no reset on payload
	logic [WIDTH-1:0] entries [DEPTH];
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	// Dequeue on an empty FIFO is a no-op
	assign push = enqueue_en;
	assign pop = dequeue_en && !empty;

	assign empty = count == '0;
	assign full = count == COUNT_WIDTH'(DEPTH);

	// Head is always visible
	assign value_out = entries[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= value_in;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at DEPTH, not at a power of two
			if (push)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Both at once leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Writer must check full
	no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		full |-> !enqueue_en);

endmodule

// ==== source/uart.sv ====
`timescale 1ns/1ps

module uart
#(
	parameter BASE_ADDRESS = 0,
	// Clock rate over (baud * 8)
	parameter BAUD_DIVIDE = 1
)
(
	input clk,
	input rst_n,

	// IO bus
	input [31:0] io_address,
	input io_read_en,
	input [31:0] io_write_data,
	input io_write_en,
	output logic [31:0] io_read_data,

	// Serial line
	output uart_tx,
	input uart_rx
);

	localparam int DATA_BITS = uart_line_pkg::DATA_BITS;
	localparam int ENTRY_WIDTH = uart_reg_pkg::ENTRY_WIDTH;
	localparam int FLAG_WIDTH = uart_reg_pkg::FLAG_WIDTH;

	// Absolute register addresses
	localparam logic [31:0] STATUS_ADDR = BASE_ADDRESS + uart_reg_pkg::STATUS_OFFSET;
	localparam logic [31:0] RX_ADDR = BASE_ADDRESS + uart_reg_pkg::RX_OFFSET;
	localparam logic [31:0] TX_ADDR = BASE_ADDRESS + uart_reg_pkg::TX_OFFSET;

	logic tx_enable;
	logic tx_ready;
	logic [DATA_BITS-1:0] rx_char;
	logic rx_char_valid;
	logic rx_frame_error;
	logic rx_break_error;
	logic enqueue_en;
	logic dequeue_en;
	logic fifo_empty;
	logic fifo_full;
	logic [ENTRY_WIDTH-1:0] entry_in;
	logic [ENTRY_WIDTH-1:0] entry_out;
	logic [FLAG_WIDTH-1:0] head_flags;
	// A character was lost, flag the next one stored
	logic overflow_pending;

	// Register strobes
	assign tx_enable = io_write_en && io_address == TX_ADDR;
	assign dequeue_en = io_read_en && io_address == RX_ADDR;

	// Drop the character when there is no room
	assign enqueue_en = rx_char_valid && !fifo_full;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			overflow_pending <= 1'b0;
		else if (rx_char_valid && fifo_full)
			overflow_pending <= 1'b1;
		else if (enqueue_en)
			overflow_pending <= 1'b0;
	end

	// Entry layout
	// Flag bits above the character follow STATUS bit order
	always_comb
	begin
		entry_in = '0;
		entry_in[DATA_BITS-1:0] = rx_char;
		entry_in[DATA_BITS + uart_reg_pkg::ST_OVERFLOW_BIT] = overflow_pending;
		entry_in[DATA_BITS + uart_reg_pkg::ST_BREAK_BIT] = rx_break_error;
		entry_in[DATA_BITS + uart_reg_pkg::ST_FRAME_BIT] = rx_frame_error;
		// No parity on the line
		entry_in[DATA_BITS + uart_reg_pkg::ST_PARITY_BIT] = 1'b0;
	end

	assign head_flags = entry_out[ENTRY_WIDTH-1 -: FLAG_WIDTH];

	// Read mux, combinational from the address
	always_comb
	begin
		io_read_data = '0;
		if (io_address == STATUS_ADDR)
		begin
			io_read_data[uart_reg_pkg::ST_RX_AVAIL_BIT] = !fifo_empty;
			io_read_data[uart_reg_pkg::ST_TX_READY_BIT] = tx_ready;
			// Flags read as zero with nothing queued
			if (!fifo_empty)
				io_read_data[FLAG_WIDTH-1:0] = head_flags;
		end
		else
			io_read_data[ENTRY_WIDTH-1:0] = entry_out;
	end

	// Transmit divider counts whole bit times
	uart_transmit #(.BAUD_DIVIDE(BAUD_DIVIDE * uart_line_pkg::OVERSAMPLE)) uart_transmit (
		.clk(clk),
		.rst_n(rst_n),
		.tx_char(io_write_data[DATA_BITS-1:0]),
		.tx_enable(tx_enable),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx));

	uart_receive #(.BAUD_DIVIDE(BAUD_DIVIDE)) uart_receive (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.rx_frame_error(rx_frame_error),
		.rx_break_error(rx_break_error));

	sync_fifo #(.WIDTH(ENTRY_WIDTH), .DEPTH(uart_reg_pkg::RX_FIFO_DEPTH)) rx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.enqueue_en(enqueue_en),
		.value_in(entry_in),
		.dequeue_en(dequeue_en),
		.value_out(entry_out),
		.empty(fifo_empty),
		.full(fifo_full));

	// Bus master never reads and writes in one cycle
	bus_one_access: assert property (@(posedge clk) disable iff (!rst_n)
		!(io_read_en && io_write_en));

endmodule

// ==== source/uart_line_pkg.sv ====
package uart_line_pkg;

	// Receiver samples per bit time
	// Transmit divider is scaled by the same factor
	localparam int OVERSAMPLE = 8;

	// Character size of an 8N1 frame
	// No parity bit is sent or expected
	localparam int DATA_BITS = 8;

	// Level of a quiet line
	// Also the stop bit level, start bit is the inverse
	localparam logic LINE_IDLE = 1'b1;

endpackage

// ==== source/uart_receive.sv ====
`timescale 1ns/1ps

module uart_receive
#(
	// Clocks per oversample tick
	parameter BAUD_DIVIDE = 1
)
(
	input clk,
	input rst_n,
	input uart_rx,
	output logic [uart_line_pkg::DATA_BITS-1:0] rx_char,
	output logic rx_char_valid,
	output logic rx_frame_error,
	output logic rx_break_error
);

	localparam int OVERSAMPLE = uart_line_pkg::OVERSAMPLE;
	localparam int DATA_BITS = uart_line_pkg::DATA_BITS;
	localparam int TICK_WIDTH = $clog2(BAUD_DIVIDE + 1);
	localparam int SAMPLE_WIDTH = $clog2(OVERSAMPLE);
	localparam int INDEX_WIDTH = $clog2(DATA_BITS);

	// FSM encoding
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_STOP = 2'd3;

	logic rx_meta;
	logic rx_sync;
	// Line level at the previous tick
	logic rx_last;
	logic [TICK_WIDTH-1:0] tick_count;
	logic tick;
	logic [1:0] state;
	// Ticks since the last sample point
	logic [SAMPLE_WIDTH-1:0] sample_count;
	logic [INDEX_WIDTH-1:0] bit_index;
	logic sample_now;
	logic line_low;

	// Two flops against metastability
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rx_meta <= uart_line_pkg::LINE_IDLE;
			rx_sync <= uart_line_pkg::LINE_IDLE;
		end
		else
		begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	// Oversample tick
	assign tick = tick_count == TICK_WIDTH'(BAUD_DIVIDE - 1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			tick_count <= '0;
		else if (tick)
			tick_count <= '0;
		else
			tick_count <= tick_count + 1'b1;
	end

	assign line_low = rx_sync != uart_line_pkg::LINE_IDLE;

	// Mid-bit point in data and stop states
	assign sample_now = tick && sample_count == SAMPLE_WIDTH'(OVERSAMPLE - 1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			rx_last <= uart_line_pkg::LINE_IDLE;
			sample_count <= '0;
			bit_index <= '0;
			rx_char_valid <= 1'b0;
		end
		else
		begin
			rx_char_valid <= 1'b0;
			if (tick)
				rx_last <= rx_sync;

			case (state)
				S_IDLE:
					// Falling edge only, a held low line never restarts
					if (tick && rx_last == uart_line_pkg::LINE_IDLE && line_low)
					begin
						state <= S_START;
						sample_count <= '0;
					end

				S_START:
					if (tick)
					begin
						if (sample_count == SAMPLE_WIDTH'(OVERSAMPLE / 2 - 1))
						begin
							// Still low at half a bit, real start bit
							state <= line_low ? S_DATA : S_IDLE;
							sample_count <= '0;
							bit_index <= '0;
						end
						else
							sample_count <= sample_count + 1'b1;
					end

				S_DATA:
					if (sample_now)
					begin
						// LSB first
						rx_char <= {rx_sync, rx_char[DATA_BITS-1:1]};
						sample_count <= '0;
						bit_index <= bit_index + 1'b1;
						if (bit_index == INDEX_WIDTH'(DATA_BITS - 1))
							state <= S_STOP;
					end
					else if (tick)
						sample_count <= sample_count + 1'b1;

				S_STOP:
					if (sample_now)
					begin
						rx_char_valid <= 1'b1;
						// Low stop bit
						rx_frame_error <= line_low;
						// Low stop and all-zero data
						rx_break_error <= line_low && rx_char == '0;
						state <= S_IDLE;
					end
					else if (tick)
						sample_count <= sample_count + 1'b1;

				default:
					state <= S_IDLE;
			endcase
		end
	end

	// One pulse per frame
	rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rx_char_valid |=> !rx_char_valid);

endmodule

// ==== source/uart_reg_pkg.sv ====
package uart_reg_pkg;

	// Register byte offsets
	// Each one is added to BASE_ADDRESS of the uart instance
	localparam int STATUS_OFFSET = 0;
	// Read pops the receive FIFO
	localparam int RX_OFFSET = 4;
	// Write starts a frame on the line
	localparam int TX_OFFSET = 8;

	// STATUS bit positions
	// Low four bits mirror the flags of the FIFO head
	localparam int ST_PARITY_BIT = 0;
	localparam int ST_FRAME_BIT = 1;
	localparam int ST_BREAK_BIT = 2;
	localparam int ST_OVERFLOW_BIT = 3;
	// Transmitter idle, a TX write will be taken
	localparam int ST_TX_READY_BIT = 4;
	// FIFO holds at least one entry
	localparam int ST_RX_AVAIL_BIT = 5;

	// Receive FIFO entry
	// Flags sit above the 8-bit character in STATUS order
	// Overflow on top, parity at the bottom
	localparam int FLAG_WIDTH = 4;
	localparam int ENTRY_WIDTH = 12;

	// Entries held before incoming characters get dropped
	localparam int RX_FIFO_DEPTH = 8;

endpackage

// ==== source/uart_transmit.sv ====
`timescale 1ns/1ps

module uart_transmit
#(
	// Clocks per bit time
	parameter BAUD_DIVIDE = 8
)
(
	input clk,
	input rst_n,
	input [uart_line_pkg::DATA_BITS-1:0] tx_char,
	input tx_enable,
	output tx_ready,
	output uart_tx
);

	// Start bit, data, stop bit
	localparam int FRAME_BITS = uart_line_pkg::DATA_BITS + 2;
	localparam int COUNT_WIDTH = $clog2(BAUD_DIVIDE + 1);
	localparam int BITS_WIDTH = $clog2(FRAME_BITS + 1);

	logic busy;
	// Clocks left in the current bit
	logic [COUNT_WIDTH-1:0] baud_count;
	// Bits left in the frame
	logic [BITS_WIDTH-1:0] bits_left;
	// Line bits, bit 0 is on the wire
	logic [FRAME_BITS-1:0] shift;
	logic bit_end;

	assign bit_end = baud_count == '0;
	assign tx_ready = !busy;
	assign uart_tx = shift[0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			baud_count <= '0;
			bits_left <= '0;
			// Quiet line out of reset
			shift <= {FRAME_BITS{uart_line_pkg::LINE_IDLE}};
		end
		else if (!busy)
		begin
			// Only accepted while ready
			if (tx_enable)
			begin
				busy <= 1'b1;
				baud_count <= COUNT_WIDTH'(BAUD_DIVIDE - 1);
				bits_left <= BITS_WIDTH'(FRAME_BITS);
				shift <= {uart_line_pkg::LINE_IDLE, tx_char, !uart_line_pkg::LINE_IDLE};
			end
		end
		else if (bit_end)
		begin
			// Next bit, idle level fills from the top
			baud_count <= COUNT_WIDTH'(BAUD_DIVIDE - 1);
			bits_left <= bits_left - 1'b1;
			shift <= {uart_line_pkg::LINE_IDLE, shift[FRAME_BITS-1:1]};
			// Stop bit done
			if (bits_left == BITS_WIDTH'(1))
				busy <= 1'b0;
		end
		else
			baud_count <= baud_count - 1'b1;
	end

	// Line holds each bit for a whole bit period
	tx_bit_stable: assert property (@(posedge clk) disable iff (!rst_n)
		busy && !bit_end |=> $stable(uart_tx));

endmodule

// ==== verif/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

	localparam logic [31:0] BASE_ADDRESS = 32'h100;
	localparam int BAUD_DIVIDE = 2;
	// One serial bit in clocks
	localparam int BIT_CLOCKS = BAUD_DIVIDE * uart_line_pkg::OVERSAMPLE;
	localparam int ENTRY_WIDTH = uart_reg_pkg::ENTRY_WIDTH;
	localparam logic [31:0] STATUS_ADDR = BASE_ADDRESS + uart_reg_pkg::STATUS_OFFSET;
	localparam logic [31:0] RX_ADDR = BASE_ADDRESS + uart_reg_pkg::RX_OFFSET;
	localparam logic [31:0] TX_ADDR = BASE_ADDRESS + uart_reg_pkg::TX_OFFSET;
	// STATUS reads before giving up
	localparam int POLL_LIMIT = 200;
	// Clocks to wait for a start bit
	localparam int LINE_LIMIT = 400;
	localparam logic [31:0] SEED = 32'h22ff_9cdc;

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] io_address;
	logic io_read_en;
	logic [31:0] io_write_data;
	logic io_write_en;
	logic [31:0] io_read_data;
	logic uart_tx;
	logic uart_rx;

	int error_count = 0;
	int check_count = 0;
	// Entries that RX reads must return, oldest first
	logic [ENTRY_WIDTH-1:0] expected_q [$];

	uart #(.BASE_ADDRESS(BASE_ADDRESS), .BAUD_DIVIDE(BAUD_DIVIDE)) dut (
		.clk(clk),
		.rst_n(rst_n),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_data(io_write_data),
		.io_write_en(io_write_en),
		.io_read_data(io_read_data),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx));

	always #5 clk = ~clk;

	// Overflow, break, frame, parity from the top, then the character
	function automatic logic [ENTRY_WIDTH-1:0] expected_entry(input logic [7:0] ch,
		input logic frame, input logic brk, input logic ovf);
		// Parity is never generated
		return {ovf, brk, frame, 1'b0, ch};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
		else
		begin
			$display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		io_address = addr;
		io_read_en = 1'b1;
		// Value before the edge, pop happens at this edge
		@(posedge clk);
		data = io_read_data;
		@(negedge clk);
		io_read_en = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		io_address = addr;
		io_write_data = data;
		io_write_en = 1'b1;
		@(negedge clk);
		io_write_en = 1'b0;
	endtask

	task automatic check_status(input logic avail, input logic [3:0] flags);
		logic [31:0] got;
		logic [31:0] want;
		bus_read(STATUS_ADDR, got);
		want = '0;
		want[uart_reg_pkg::ST_RX_AVAIL_BIT] = avail;
		want[uart_reg_pkg::ST_TX_READY_BIT] = 1'b1;
		want[3:0] = flags;
		check_value("STATUS io_read_data", want, got);
	endtask

	task automatic wait_tx_ready();
		logic [31:0] st;
		int polls;
		polls = 0;
		bus_read(STATUS_ADDR, st);
		while (st[uart_reg_pkg::ST_TX_READY_BIT] !== 1'b1 && polls < POLL_LIMIT)
		begin
			bus_read(STATUS_ADDR, st);
			polls++;
		end
		if (st[uart_reg_pkg::ST_TX_READY_BIT] !== 1'b1)
		begin
			$display("Timeout waiting for tx_ready in STATUS");
			error_count++;
		end
	endtask

	task automatic wait_rx_avail();
		logic [31:0] st;
		int polls;
		polls = 0;
		bus_read(STATUS_ADDR, st);
		while (st[uart_reg_pkg::ST_RX_AVAIL_BIT] !== 1'b1 && polls < POLL_LIMIT)
		begin
			bus_read(STATUS_ADDR, st);
			polls++;
		end
		if (st[uart_reg_pkg::ST_RX_AVAIL_BIT] !== 1'b1)
		begin
			$display("Timeout waiting for rx_avail in STATUS");
			error_count++;
		end
	endtask

	// LSB first, optional low stop bit, one idle bit after
	task automatic send_frame(input logic [7:0] ch, input logic bad_stop);
		@(negedge clk);
		uart_rx = 1'b0;
		repeat (BIT_CLOCKS) @(negedge clk);
		for (int i = 0; i < uart_line_pkg::DATA_BITS; i++)
		begin
			uart_rx = ch[i];
			repeat (BIT_CLOCKS) @(negedge clk);
		end
		uart_rx = !bad_stop;
		repeat (BIT_CLOCKS) @(negedge clk);
		uart_rx = 1'b1;
		repeat (BIT_CLOCKS) @(negedge clk);
	endtask

	// Line held low for a whole frame
	task automatic send_break();
		@(negedge clk);
		uart_rx = 1'b0;
		repeat (10 * BIT_CLOCKS) @(negedge clk);
		uart_rx = 1'b1;
		repeat (2 * BIT_CLOCKS) @(negedge clk);
	endtask

	// Rebuild one character from uart_tx, sampled mid-bit
	task automatic monitor_frame(output logic [7:0] ch);
		int waited;
		waited = 0;
		ch = '0;
		@(posedge clk);
		while (uart_tx !== 1'b0 && waited < LINE_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (uart_tx !== 1'b0)
		begin
			$display("Timeout waiting for a start bit on uart_tx");
			error_count++;
		end
		else
		begin
			repeat (BIT_CLOCKS / 2 - 1) @(posedge clk);
			check_value("uart_tx start bit", 32'h0, uart_tx);
			for (int i = 0; i < uart_line_pkg::DATA_BITS; i++)
			begin
				repeat (BIT_CLOCKS) @(posedge clk);
				ch[i] = uart_tx;
			end
			repeat (BIT_CLOCKS) @(posedge clk);
			check_value("uart_tx stop bit", 32'h1, uart_tx);
		end
	endtask

	// Every RX read against the next queued entry
	always @(posedge clk)
	begin : compare_rx_reads
		logic [ENTRY_WIDTH-1:0] want;
		if (rst_n === 1'b1 && io_read_en === 1'b1 && io_address === RX_ADDR)
		begin
			check_count++;
			assert (expected_q.size() > 0)
			else
			begin
				$display("RX read found no expected entry queued");
				error_count++;
			end
			if (expected_q.size() > 0)
			begin
				want = expected_q.pop_front();
				check_value("RX io_read_data", {20'h0, want}, io_read_data);
			end
		end
	end

	initial
	begin : run_tests
		logic [31:0] rnd;
		logic [7:0] ch;
		logic [7:0] got;
		logic [31:0] st;
		logic idle_ok;
		logic [ENTRY_WIDTH-1:0] want;
		rnd = $urandom(SEED);
		rst_n = 1'b0;
		io_address = '0;
		io_read_en = 1'b0;
		io_write_data = '0;
		io_write_en = 1'b0;
		uart_rx = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Reset state
		check_status(1'b0, 4'h0);
		check_value("uart_tx", 32'h1, uart_tx);

		// Transmit, one mid-frame write ignored
		for (int i = 0; i < 20; i++)
		begin
			rnd = $urandom();
			ch = rnd[7:0];
			wait_tx_ready();
			fork
				monitor_frame(got);
				begin
					bus_write(TX_ADDR, {24'h0, ch});
					if (i == 5)
					begin
						repeat (3 * BIT_CLOCKS) @(negedge clk);
						bus_read(STATUS_ADDR, st);
						check_value("STATUS tx_ready", 32'h0, st[uart_reg_pkg::ST_TX_READY_BIT]);
						bus_write(TX_ADDR, {24'h0, ~ch});
					end
				end
			join
			check_value("uart_tx character", ch, got);
			if (i == 5)
			begin
				// No second frame may follow
				wait_tx_ready();
				idle_ok = 1'b1;
				repeat (2 * BIT_CLOCKS)
				begin
					@(posedge clk);
					if (uart_tx !== 1'b1)
						idle_ok = 1'b0;
				end
				check_value("uart_tx idle after busy write", 32'h1, idle_ok);
			end
		end

		// Receive in order
		for (int i = 0; i < 6; i++)
		begin
			rnd = $urandom();
			expected_q.push_back(expected_entry(rnd[7:0], 1'b0, 1'b0, 1'b0));
			send_frame(rnd[7:0], 1'b0);
		end
		wait_rx_avail();
		check_status(1'b1, 4'h0);
		repeat (6) bus_read(RX_ADDR, st);
		check_status(1'b0, 4'h0);

		// Low stop bit
		rnd = $urandom();
		ch = rnd[7:0] | 8'h01;
		send_frame(ch, 1'b1);
		wait_rx_avail();
		want = expected_entry(ch, 1'b1, 1'b0, 1'b0);
		expected_q.push_back(want);
		check_status(1'b1, want[ENTRY_WIDTH-1 -: 4]);
		bus_read(RX_ADDR, st);

		// Break
		send_break();
		wait_rx_avail();
		want = expected_entry(8'h00, 1'b1, 1'b1, 1'b0);
		expected_q.push_back(want);
		check_status(1'b1, want[ENTRY_WIDTH-1 -: 4]);
		bus_read(RX_ADDR, st);
		check_status(1'b0, 4'h0);

		// Overflow, the last frame before draining is lost
		for (int i = 0; i <= uart_reg_pkg::RX_FIFO_DEPTH; i++)
		begin
			rnd = $urandom();
			if (i < uart_reg_pkg::RX_FIFO_DEPTH)
				expected_q.push_back(expected_entry(rnd[7:0], 1'b0, 1'b0, 1'b0));
			send_frame(rnd[7:0], 1'b0);
		end
		repeat (uart_reg_pkg::RX_FIFO_DEPTH) bus_read(RX_ADDR, st);
		check_status(1'b0, 4'h0);
		rnd = $urandom();
		want = expected_entry(rnd[7:0], 1'b0, 1'b0, 1'b1);
		expected_q.push_back(want);
		send_frame(rnd[7:0], 1'b0);
		wait_rx_avail();
		check_status(1'b1, want[ENTRY_WIDTH-1 -: 4]);
		bus_read(RX_ADDR, st);
		check_status(1'b0, 4'h0);

		check_value("expected entries left", 32'h0, expected_q.size());
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
